// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - mem_pkg.sv
  - lsu_req_stage.sv
  - lsu_bus_ctrl.sv
  - lsu_load_format.sv
  - data_ram_slave.sv
  - mem_stage_top.sv
  - target: test
    files:
      - mem_stage_chk.sv
      - tb_mem_stage.sv

// ==== data_ram_slave.sv ====
// data memory model behind the stage, answers each channel after RESP_DELAY cycles
`timescale 1ns/10ps
`default_nettype none

module data_ram_slave #(
  parameter int RAM_WORDS  = 256,
  parameter int RESP_DELAY = 2
) (
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         wr_valid_i,
  input  wire  [63:0] wr_addr_i,
  input  wire  [63:0] wr_data_i,
  input  wire  [7:0]  wr_strb_i,
  input  wire         wresp_ready_i,
  input  wire         rd_valid_i,
  input  wire  [63:0] rd_addr_i,
  input  wire         rdata_ready_i,
  output logic        wr_ready_o,
  output logic        wresp_valid_o,
  output logic        rd_ready_o,
  output logic        rdata_valid_o,
  output logic [63:0] rdata_o
);

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int CNT_W = $clog2(RESP_DELAY + 2);
  localparam logic [CNT_W-1:0] DLY = CNT_W'(RESP_DELAY);

  logic [63:0]      mem_q [RAM_WORDS];
  logic             clearing_q;
  logic [IDX_W-1:0] clr_idx_q;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic [CNT_W-1:0] wr_cnt_q;
  logic [CNT_W-1:0] wresp_cnt_q;
  logic [CNT_W-1:0] rd_cnt_q;
  logic [CNT_W-1:0] rdata_cnt_q;
  logic             wresp_pend_q;
  logic             rdata_pend_q;
  logic             wr_fire;
  logic             rd_fire;

  assign wr_idx = IDX_W'(wr_addr_i[63:3] % RAM_WORDS);
  assign rd_idx = IDX_W'(rd_addr_i[63:3] % RAM_WORDS);

  // nothing is accepted until the sweep is through
  assign wr_ready_o    = wr_valid_i && !clearing_q && (wr_cnt_q == DLY);
  assign rd_ready_o    = rd_valid_i && !clearing_q && (rd_cnt_q == DLY);
  assign wresp_valid_o = wresp_pend_q && (wresp_cnt_q == DLY);
  assign rdata_valid_o = rdata_pend_q && (rdata_cnt_q == DLY);

  assign wr_fire = wr_valid_i && wr_ready_o;
  assign rd_fire = rd_valid_i && rd_ready_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      clearing_q   <= 1'b1;
      clr_idx_q    <= '0;
      wr_cnt_q     <= '0;
      rd_cnt_q     <= '0;
      wresp_cnt_q  <= '0;
      rdata_cnt_q  <= '0;
      wresp_pend_q <= 1'b0;
      rdata_pend_q <= 1'b0;
    end else begin
      if (clearing_q) begin
        clr_idx_q <= clr_idx_q + 1'b1;
        if (clr_idx_q == IDX_W'(RAM_WORDS - 1)) clearing_q <= 1'b0;
      end
      // request side delay, counts while a valid is pending
      if (wr_fire || !wr_valid_i || clearing_q) wr_cnt_q <= '0;
      else if (wr_cnt_q != DLY) wr_cnt_q <= wr_cnt_q + 1'b1;
      if (rd_fire || !rd_valid_i || clearing_q) rd_cnt_q <= '0;
      else if (rd_cnt_q != DLY) rd_cnt_q <= rd_cnt_q + 1'b1;
      // response side delay
      if (wr_fire) begin
        wresp_pend_q <= 1'b1;
        wresp_cnt_q  <= '0;
      end else if (wresp_valid_o && wresp_ready_i) begin
        wresp_pend_q <= 1'b0;
      end else if (wresp_pend_q && wresp_cnt_q != DLY) begin
        wresp_cnt_q <= wresp_cnt_q + 1'b1;
      end
      if (rd_fire) begin
        rdata_pend_q <= 1'b1;
        rdata_cnt_q  <= '0;
      end else if (rdata_valid_o && rdata_ready_i) begin
        rdata_pend_q <= 1'b0;
      end else if (rdata_pend_q && rdata_cnt_q != DLY) begin
        rdata_cnt_q <= rdata_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clearing_q) begin
      mem_q[clr_idx_q] <= '0;
    end else if (wr_fire) begin
      for (int b = 0; b < 8; b++) begin
        if (wr_strb_i[b]) mem_q[wr_idx][8*b +: 8] <= wr_data_i[8*b +: 8];
      end
    end
    if (rd_fire) rdata_o <= mem_q[rd_idx];  // held until the data transfer
  end

endmodule

`default_nettype wire

// ==== lsu_bus_ctrl.sv ====
// bus side of the memory stage: runs the valid/ready write and read handshakes per access
`timescale 1ns/10ps
`default_nettype none

module lsu_bus_ctrl (
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         start_i,
  input  wire         is_store_i,
  input  wire  [63:0] addr_i,
  input  wire  [63:0] wdata_i,
  input  wire  [7:0]  strb_i,
  input  wire         wr_ready_i,
  input  wire         wresp_valid_i,
  input  wire         rd_ready_i,
  input  wire         rdata_valid_i,
  input  wire  [63:0] rdata_i,
  output logic        wr_valid_o,
  output logic [63:0] wr_addr_o,
  output logic [63:0] wr_data_o,
  output logic [7:0]  wr_strb_o,
  output logic        wresp_ready_o,
  output logic        rd_valid_o,
  output logic [63:0] rd_addr_o,
  output logic        rdata_ready_o,
  output logic        fin_o,
  output logic [63:0] rd_word_o
);

  mem_pkg::bus_state_e state_q;
  mem_pkg::bus_state_e state_d;
  logic [63:0]         addr_q;
  logic [63:0]         wdata_q;
  logic [7:0]          strb_q;
  logic                wresp_hs;
  logic                rdata_hs;

  // valids and readies come straight from the state, so they hold until the transfer
  assign wr_valid_o    = (state_q == mem_pkg::st_wr_req);
  assign wresp_ready_o = (state_q == mem_pkg::st_wr_resp);
  assign rd_valid_o    = (state_q == mem_pkg::st_rd_req);
  assign rdata_ready_o = (state_q == mem_pkg::st_rd_data);

  assign wr_addr_o = addr_q;
  assign wr_data_o = wdata_q;
  assign wr_strb_o = strb_q;
  assign rd_addr_o = addr_q;

  assign wresp_hs = wresp_valid_i && wresp_ready_o;
  assign rdata_hs = rdata_valid_i && rdata_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      mem_pkg::st_idle: begin
        if (start_i) begin
          state_d = is_store_i ? mem_pkg::st_wr_req : mem_pkg::st_rd_req;
        end
      end
      mem_pkg::st_wr_req: begin
        if (wr_ready_i) state_d = mem_pkg::st_wr_resp;
      end
      mem_pkg::st_wr_resp: begin
        if (wresp_hs) state_d = mem_pkg::st_idle;
      end
      mem_pkg::st_rd_req: begin
        if (rd_ready_i) state_d = mem_pkg::st_rd_data;
      end
      mem_pkg::st_rd_data: begin
        if (rdata_hs) state_d = mem_pkg::st_idle;
      end
      default: state_d = mem_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= mem_pkg::st_idle;
      fin_o   <= 1'b0;
    end else begin
      state_q <= state_d;
      fin_o   <= wresp_hs || rdata_hs;  // one cycle after the last handshake
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && state_q == mem_pkg::st_idle) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      strb_q  <= strb_i;
    end
    if (rdata_hs) rd_word_o <= rdata_i;
  end

endmodule

`default_nettype wire

// ==== lsu_load_format.sv ====
// result side of the memory stage: extracts and extends load data, pulses done
`timescale 1ns/10ps
`default_nettype none

module lsu_load_format (
  input  wire                 clk,
  input  wire                 rst_n_i,
  input  wire                 fin_i,
  input  wire [63:0]          rd_word_i,
  input  wire [2:0]           offset_i,
  input  wire mem_pkg::mem_size_e size_i,
  input  wire                 sext_i,
  input  wire                 is_store_i,
  output logic                done_o,
  output logic [63:0]         rdata_o
);

  logic [63:0] shifted;
  logic [63:0] formatted;

  assign shifted = rd_word_i >> {offset_i, 3'b000};  // selected bytes down to lane 0

  always_comb begin
    case (size_i)
      mem_pkg::sz_byte: formatted = {{56{sext_i & shifted[7]}}, shifted[7:0]};
      mem_pkg::sz_half: formatted = {{48{sext_i & shifted[15]}}, shifted[15:0]};
      mem_pkg::sz_word: formatted = {{32{sext_i & shifted[31]}}, shifted[31:0]};
      default:          formatted = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      done_o  <= 1'b0;
      rdata_o <= '0;
    end else begin
      done_o <= fin_i;
      if (fin_i && !is_store_i) begin
        rdata_o <= formatted;  // stores keep the last load value
      end
    end
  end

endmodule

`default_nettype wire

// ==== lsu_req_stage.sv ====
// request side of the memory stage: accepts a request, aligns store lanes, owns busy
`timescale 1ns/10ps
`default_nettype none

module lsu_req_stage (
  input  wire                 clk,
  input  wire                 rst_n_i,
  input  wire                 req_valid_i,
  input  wire mem_pkg::mem_op_e   req_op_i,
  input  wire [63:0]          req_addr_i,
  input  wire [63:0]          req_wdata_i,
  input  wire mem_pkg::mem_size_e req_size_i,
  input  wire                 req_sext_i,
  input  wire                 done_i,
  output logic                start_o,
  output logic                is_store_o,
  output logic [63:0]         addr_o,
  output logic [63:0]         wdata_o,
  output logic [7:0]          strb_o,
  output logic [2:0]          offset_o,
  output mem_pkg::mem_size_e  size_o,
  output logic                sext_o,
  output logic                busy_o
);

  logic       accept;
  logic [7:0] size_mask;
  logic [5:0] lane_shift;

  assign accept     = req_valid_i && !busy_o;  // pulses while busy are dropped
  assign lane_shift = {req_addr_i[2:0], 3'b000};

  always_comb begin
    case (req_size_i)
      mem_pkg::sz_byte: size_mask = 8'h01;
      mem_pkg::sz_half: size_mask = 8'h03;
      mem_pkg::sz_word: size_mask = 8'h0f;
      default:          size_mask = 8'hff;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      start_o <= 1'b0;
      busy_o  <= 1'b0;
    end else begin
      start_o <= accept;
      if (accept) begin
        busy_o <= 1'b1;
      end else if (done_i) begin
        busy_o <= 1'b0;
      end
    end
  end

  // fields stay put until the next accept, load formatting relies on that
  always_ff @(posedge clk) begin
    if (accept) begin
      is_store_o <= (req_op_i == mem_pkg::op_store);
      addr_o     <= req_addr_i;
      wdata_o    <= req_wdata_i << lane_shift;
      strb_o     <= size_mask << req_addr_i[2:0];
      offset_o   <= req_addr_i[2:0];
      size_o     <= req_size_i;
      sext_o     <= req_sext_i;
    end
  end

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
// enums shared by the memory stage and its testbench, used through scoped names
`default_nettype none

package mem_pkg;

  typedef enum logic [0:0] {
    op_load  = 1'b0,
    op_store = 1'b1
  } mem_op_e;

  // access width, bytes = 1 << size
  typedef enum logic [1:0] {
    sz_byte  = 2'd0,
    sz_half  = 2'd1,
    sz_word  = 2'd2,
    sz_dword = 2'd3
  } mem_size_e;

  typedef enum logic [2:0] {
    st_idle    = 3'd0,
    st_wr_req  = 3'd1,  // address, data and strobe offered
    st_wr_resp = 3'd2,
    st_rd_req  = 3'd3,
    st_rd_data = 3'd4   // waiting for the read word
  } bus_state_e;

endpackage

`default_nettype wire

// ==== mem_stage_chk.sv ====
// protocol checker for the memory stage that the testbench binds into mem_stage_top
`timescale 1ns/10ps
`default_nettype none

module mem_stage_chk (
  input wire                      clk,
  input wire                      rst_n_i,
  input wire                      req_valid_i,
  input wire [63:0]               req_addr_i,
  input wire mem_pkg::mem_size_e  req_size_i,
  input wire                      busy_i,
  input wire                      done_i,
  input wire mem_pkg::bus_state_e state_i,
  input wire                      wr_valid_i,
  input wire [63:0]               wr_addr_i,
  input wire [63:0]               wr_data_i,
  input wire [7:0]                wr_strb_i,
  input wire                      wr_ready_i,
  input wire                      wresp_valid_i,
  input wire                      wresp_ready_i,
  input wire                      rd_valid_i,
  input wire [63:0]               rd_addr_i,
  input wire                      rd_ready_i,
  input wire                      rdata_valid_i,
  input wire [63:0]               rdata_i,
  input wire                      rdata_ready_i
);

  int unsigned fail_cnt = 0;  // count of failed assertions
  logic [2:0]  align_mask;

  always_comb begin
    case (req_size_i)
      mem_pkg::sz_byte: align_mask = 3'b000;
      mem_pkg::sz_half: align_mask = 3'b001;
      mem_pkg::sz_word: align_mask = 3'b011;
      default:          align_mask = 3'b111;
    endcase
  end

  wr_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_valid_i && !wr_ready_i |=> wr_valid_i && $stable({wr_addr_i, wr_data_i, wr_strb_i}))
    else begin
      $error("write request dropped or changed before wr_ready");
      fail_cnt++;
    end

  wresp_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    wresp_valid_i && !wresp_ready_i |=> wresp_valid_i)
    else begin
      $error("write response dropped before wresp_ready");
      fail_cnt++;
    end

  rd_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    rd_valid_i && !rd_ready_i |=> rd_valid_i && $stable(rd_addr_i))
    else begin
      $error("read request dropped or changed before rd_ready");
      fail_cnt++;
    end

  rdata_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    rdata_valid_i && !rdata_ready_i |=> rdata_valid_i && $stable(rdata_i))
    else begin
      $error("read data dropped or changed before rdata_ready");
      fail_cnt++;
    end

  done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    done_i |=> !done_i && !busy_i)
    else begin
      $error("done_o longer than one cycle or busy_o still high after it");
      fail_cnt++;
    end

  // bus controller is back in idle once the access is reported done
  done_idle_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    done_i |-> state_i == mem_pkg::st_idle)
    else begin
      $error("bus controller not idle at done_o");
      fail_cnt++;
    end

  no_req_busy_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_valid_i |-> !busy_i)
    else begin
      $error("request pulse while busy_o is high");
      fail_cnt++;
    end

  aligned_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_valid_i && !busy_i |-> (req_addr_i[2:0] & align_mask) == 3'b000)
    else begin
      $error("request address not aligned to its size");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== mem_stage_top.sv ====
// memory-access stage top: request, bus and format parts plus the data memory
`timescale 1ns/10ps
`default_nettype none

module mem_stage_top #(
  parameter int RAM_WORDS  = 256,
  parameter int RESP_DELAY = 2
) (
  input  wire                 clk,
  input  wire                 rst_n_i,
  input  wire                 req_valid_i,
  input  wire mem_pkg::mem_op_e   req_op_i,
  input  wire [63:0]          req_addr_i,
  input  wire [63:0]          req_wdata_i,
  input  wire mem_pkg::mem_size_e req_size_i,
  input  wire                 req_sext_i,
  output logic                busy_o,
  output logic                done_o,
  output logic [63:0]         rdata_o
);

  logic               start;
  logic               is_store;
  logic [63:0]        addr;
  logic [63:0]        wdata;
  logic [7:0]         strb;
  logic [2:0]         offset;
  mem_pkg::mem_size_e size;
  logic               sext;
  logic               fin;
  logic [63:0]        rd_word;
  // memory channels
  logic               wr_valid;
  logic [63:0]        wr_addr;
  logic [63:0]        wr_data;
  logic [7:0]         wr_strb;
  logic               wr_ready;
  logic               wresp_valid;
  logic               wresp_ready;
  logic               rd_valid;
  logic [63:0]        rd_addr;
  logic               rd_ready;
  logic               rdata_valid;
  logic [63:0]        rdata;
  logic               rdata_ready;

  lsu_req_stage lsu_req_stage_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_size_i  (req_size_i),
    .req_sext_i  (req_sext_i),
    .done_i      (done_o),
    .start_o     (start),
    .is_store_o  (is_store),
    .addr_o      (addr),
    .wdata_o     (wdata),
    .strb_o      (strb),
    .offset_o    (offset),
    .size_o      (size),
    .sext_o      (sext),
    .busy_o      (busy_o)
  );

  lsu_bus_ctrl lsu_bus_ctrl_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .start_i       (start),
    .is_store_i    (is_store),
    .addr_i        (addr),
    .wdata_i       (wdata),
    .strb_i        (strb),
    .wr_ready_i    (wr_ready),
    .wresp_valid_i (wresp_valid),
    .rd_ready_i    (rd_ready),
    .rdata_valid_i (rdata_valid),
    .rdata_i       (rdata),
    .wr_valid_o    (wr_valid),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data),
    .wr_strb_o     (wr_strb),
    .wresp_ready_o (wresp_ready),
    .rd_valid_o    (rd_valid),
    .rd_addr_o     (rd_addr),
    .rdata_ready_o (rdata_ready),
    .fin_o         (fin),
    .rd_word_o     (rd_word)
  );

  lsu_load_format lsu_load_format_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .fin_i      (fin),
    .rd_word_i  (rd_word),
    .offset_i   (offset),
    .size_i     (size),
    .sext_i     (sext),
    .is_store_i (is_store),
    .done_o     (done_o),
    .rdata_o    (rdata_o)
  );

  data_ram_slave #(
    .RAM_WORDS  (RAM_WORDS),
    .RESP_DELAY (RESP_DELAY)
  ) data_ram_slave_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .wr_valid_i    (wr_valid),
    .wr_addr_i     (wr_addr),
    .wr_data_i     (wr_data),
    .wr_strb_i     (wr_strb),
    .wresp_ready_i (wresp_ready),
    .rd_valid_i    (rd_valid),
    .rd_addr_i     (rd_addr),
    .rdata_ready_i (rdata_ready),
    .wr_ready_o    (wr_ready),
    .wresp_valid_o (wresp_valid),
    .rd_ready_o    (rd_ready),
    .rdata_valid_o (rdata_valid),
    .rdata_o       (rdata)
  );

endmodule

`default_nettype wire

// ==== sim.f ====
mem_pkg.sv
lsu_req_stage.sv
lsu_bus_ctrl.sv
lsu_load_format.sv
data_ram_slave.sv
mem_stage_top.sv
mem_stage_chk.sv
tb_mem_stage.sv

// ==== tb_mem_stage.sv ====
// simulation top that runs directed and random loads and stores on the memory stage against a byte model
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;

  localparam logic [31:0] SEED    = 32'haa50136e;
  localparam int          NUM_OPS = 300;
  localparam int          TIMEOUT = 1000;  // covers the clearing sweep after reset
  localparam int          WINDOW  = 64;    // small byte window so accesses overlap

  logic               clk;
  logic               rst_n_i;
  logic               req_valid_i;
  mem_pkg::mem_op_e   req_op_i;
  logic [63:0]        req_addr_i;
  logic [63:0]        req_wdata_i;
  mem_pkg::mem_size_e req_size_i;
  logic               req_sext_i;
  logic               busy_o;
  logic               done_o;
  logic [63:0]        rdata_o;

  logic [31:0] lfsr;
  logic [7:0]  ref_mem [WINDOW];
  logic [63:0] last_rdata;  // only a load completion moves it

  mem_stage_top #(
    .RAM_WORDS  (256),
    .RESP_DELAY (2)
  ) mem_stage_top_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_size_i  (req_size_i),
    .req_sext_i  (req_sext_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .rdata_o     (rdata_o)
  );

  bind mem_stage_top mem_stage_chk mem_stage_chk_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_size_i    (req_size_i),
    .busy_i        (busy_o),
    .done_i        (done_o),
    .state_i       (lsu_bus_ctrl_i.state_q),
    .wr_valid_i    (wr_valid),
    .wr_addr_i     (wr_addr),
    .wr_data_i     (wr_data),
    .wr_strb_i     (wr_strb),
    .wr_ready_i    (wr_ready),
    .wresp_valid_i (wresp_valid),
    .wresp_ready_i (wresp_ready),
    .rd_valid_i    (rd_valid),
    .rd_addr_i     (rd_addr),
    .rd_ready_i    (rd_ready),
    .rdata_valid_i (rdata_valid),
    .rdata_i       (rdata),
    .rdata_ready_i (rdata_ready)
  );

  always #10 clk = ~clk;

  // galois form with taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      stop_on_error($sformatf("** Error at %0t: %s is %0h, expected %0h",
                              $time, name, got, exp));
    end
  endtask

  always @(negedge clk) begin
    if (mem_stage_top_i.mem_stage_chk_i.fail_cnt != 0) begin
      stop_on_error("protocol checker reported an assertion failure");
    end
  end

  // one request from pulse to done checked against the byte model
  task automatic run_access(input mem_pkg::mem_op_e op, input logic [63:0] addr,
                            input mem_pkg::mem_size_e size, input logic sext,
                            input logic [63:0] wdata);
    logic [63:0] expected;
    int          nbytes;
    int          base;
    int          wait_cycles;
    nbytes   = 1 << size;
    base     = int'(addr[5:0]);
    expected = '0;
    if (op == mem_pkg::op_store) begin
      for (int i = 0; i < nbytes; i++) ref_mem[base + i] = wdata[8*i +: 8];
      expected = last_rdata;
    end else begin
      for (int i = 0; i < nbytes; i++) expected[8*i +: 8] = ref_mem[base + i];
      if (sext && nbytes < 8 && expected[8*nbytes-1]) begin
        expected = expected | ~((64'd1 << (8*nbytes)) - 64'd1);
      end
      last_rdata = expected;
    end
    @(negedge clk);
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_size_i  = size;
    req_sext_i  = sext;
    @(negedge clk);
    req_valid_i = 1'b0;
    wait_cycles = 0;
    while (done_o !== 1'b1) begin
      check_value("busy_o", busy_o, 64'd1);
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > TIMEOUT) begin
        stop_on_error("timeout: no done_o pulse after an accepted request");
      end
    end
    check_value("busy_o", busy_o, 64'd1);
    check_value("rdata_o", rdata_o, expected);
    @(negedge clk);
    check_value("done_o", done_o, 64'd0);
    check_value("busy_o", busy_o, 64'd0);
  endtask

  task automatic random_access(input int addr_width, input bit load_only);
    logic [63:0]        ctl;
    logic [63:0]        addr;
    logic [63:0]        data;
    mem_pkg::mem_op_e   op;
    mem_pkg::mem_size_e size;
    draw_bits(4, ctl);
    draw_bits(addr_width, addr);
    draw_bits(64, data);
    op   = load_only ? mem_pkg::op_load : mem_pkg::mem_op_e'(ctl[0]);
    size = mem_pkg::mem_size_e'(ctl[2:1]);
    addr = addr & ~((64'd1 << size) - 64'd1);  // natural alignment
    run_access(op, addr, size, ctl[3], data);
  endtask

  initial begin
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = mem_pkg::op_load;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_size_i  = mem_pkg::sz_byte;
    req_sext_i  = 1'b0;
    lfsr        = SEED;
    last_rdata  = '0;
    foreach (ref_mem[i]) ref_mem[i] = 8'h00;

    repeat (5) @(negedge clk);
    rst_n_i = 1'b1;
    check_value("busy_o", busy_o, 64'd0);
    check_value("done_o", done_o, 64'd0);
    check_value("rdata_o", rdata_o, 64'd0);

    // first load also waits out the clearing sweep
    repeat (4) random_access(64, 1'b1);

    run_access(mem_pkg::op_store, 64'd8, mem_pkg::sz_dword, 1'b0, 64'h80ff_7f01_c3a5_5a3c);
    run_access(mem_pkg::op_load, 64'd8, mem_pkg::sz_dword, 1'b0, '0);

    // every aligned offset of the narrow sizes with both extensions
    for (int sz = 0; sz < 3; sz++) begin
      for (int off = 0; off < 8; off += (1 << sz)) begin
        run_access(mem_pkg::op_load, 64'(8 + off), mem_pkg::mem_size_e'(sz), 1'b0, '0);
        run_access(mem_pkg::op_load, 64'(8 + off), mem_pkg::mem_size_e'(sz), 1'b1, '0);
      end
    end

    repeat (NUM_OPS) random_access(6, 1'b0);

    for (int w = 0; w < WINDOW; w += 8) begin
      run_access(mem_pkg::op_load, 64'(w), mem_pkg::sz_dword, 1'b0, '0);
    end

    if (mem_stage_top_i.mem_stage_chk_i.fail_cnt == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      stop_on_error("protocol checker reported assertion failures");
    end
  end

endmodule

`default_nettype wire
